// File: source/rvIsaPkg.sv
// ================================================
// RV32I base encodings used by the stage decoders
// only the nine opcode classes of RV32I are known,
// fence and system opcodes decode as unknown
// funct7 is reduced to its bit 30
// ================================================
package rvIsaPkg;

	// one instruction word
	localparam int instWidth = 32;

	// field positions inside the instruction word
	localparam int opcodeHi = 6;
	localparam int opcodeLo = 0;
	localparam int funct3Hi = 14;
	localparam int funct3Lo = 12;
	localparam int altBitPos = 30;

	typedef enum logic [6:0] {
		opReg    = 7'b0110011,
		opImm    = 7'b0010011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111
	} opcodeT;

	// funct3 of register and immediate ALU ops
	typedef enum logic [2:0] {
		f3Add  = 3'd0,
		f3Sll  = 3'd1,
		f3Slt  = 3'd2,
		f3Sltu = 3'd3,
		f3Xor  = 3'd4,
		f3Sr   = 3'd5,
		f3Or   = 3'd6,
		f3And  = 3'd7
	} aluFunct3T;

	// funct3 of conditional branches
	typedef enum logic [2:0] {
		f3Beq  = 3'd0,
		f3Bne  = 3'd1,
		f3Blt  = 3'd4,
		f3Bge  = 3'd5,
		f3Bltu = 3'd6,
		f3Bgeu = 3'd7
	} branchFunct3T;

	// funct3 of loads and stores, the unsigned ones are loads only
	typedef enum logic [2:0] {
		f3Byte  = 3'd0,
		f3Half  = 3'd1,
		f3Word  = 3'd2,
		f3ByteU = 3'd4,
		f3HalfU = 3'd5
	} memFunct3T;

endpackage

// File: source/ctrlPkg.sv
// ================================================
// control encodings driven to the datapath
// value 0 of every select is also the idle value
// of an empty or unknown pipeline slot
// ================================================
package ctrlPkg;

	// select widths
	localparam int aluSelBits = 4;
	localparam int immSelBits = 3;
	localparam int memWidthBits = 3;
	localparam int wbSelBits = 2;

	typedef enum logic [aluSelBits-1:0] {
		aluAdd   = 4'd0,
		aluSub   = 4'd1,
		aluSll   = 4'd2,
		aluSlt   = 4'd3,
		aluSltu  = 4'd4,
		aluXor   = 4'd5,
		aluSrl   = 4'd6,
		aluSra   = 4'd7,
		aluOr    = 4'd8,
		aluAnd   = 4'd9,
		// operand b straight through, for lui
		aluPassB = 4'd10
	} aluOpT;

	// immediate format for the immediate generator
	typedef enum logic [immSelBits-1:0] {
		immR     = 3'd0,
		immI     = 3'd1,
		immShift = 3'd2,
		immS     = 3'd3,
		immB     = 3'd4,
		immU     = 3'd5,
		immJ     = 3'd6
	} immSelT;

	// data memory access size
	typedef enum logic [memWidthBits-1:0] {
		widthByte  = 3'd0,
		widthHalf  = 3'd1,
		widthWord  = 3'd2,
		widthByteU = 3'd3,
		widthHalfU = 3'd4
	} memWidthT;

	// register file write data source
	typedef enum logic [wbSelBits-1:0] {
		wbMem = 2'd0,
		wbAlu = 2'd1,
		wbPc4 = 2'd2
	} wbSelT;

endpackage

// File: source/instPipe.sv
`timescale 1ns/10ps
// ================================================
// instruction and valid flag through EX, MEM, WB
// stall freezes every stage and drops the input,
// so the source must hold inst while stalled
// instruction words have no reset, only the flags
// ================================================
module instPipe (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          stall,
	input  logic [rvIsaPkg::instWidth-1:0] inst,
	input  logic                          instValid,
	output logic [rvIsaPkg::instWidth-1:0] exInst,
	output logic                          exValid,
	output logic [rvIsaPkg::instWidth-1:0] memInst,
	output logic                          memValid,
	output logic [rvIsaPkg::instWidth-1:0] wbInst,
	output logic                          wbValid
);

	// valid flags, cleared by reset
	always_ff @(posedge clk) begin
		if (reset) begin
			exValid <= 1'b0;
			memValid <= 1'b0;
			wbValid <= 1'b0;
		end else if (!stall) begin
			exValid <= instValid;
			memValid <= exValid;
			wbValid <= memValid;
		end
	end

	// instruction words follow the flags
	always_ff @(posedge clk) begin
		if (!stall) begin
			exInst <= inst;
			memInst <= exInst;
			wbInst <= memInst;
		end
	end

	// a stalled pipe must not gain or lose instructions
	assert property (@(posedge clk) disable iff (reset)
		stall |=> $stable({exValid, memValid, wbValid}))
		else $error("instPipe: stage valid changed during stall");

endmodule

// File: source/executeControl.sv
`timescale 1ns/10ps
// ================================================
// execute stage decode: ALU op, immediate format,
// operand selects, compare mode and next-PC select
// pcSel follows brEq/brLt of the same cycle
// no flush follows a taken branch
// empty slot or unknown opcode drives all zeros
// ================================================
module executeControl (
	input  logic [rvIsaPkg::instWidth-1:0] exInst,
	input  logic                          exValid,
	input  logic                          brEq,
	input  logic                          brLt,
	output ctrlPkg::aluOpT                aluSel,
	output ctrlPkg::immSelT               immSel,
	output logic                          aSel,
	output logic                          bSel,
	output logic                          brUn,
	output logic                          pcSel
);
	import rvIsaPkg::*;
	import ctrlPkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic altBit;

	assign opcode = exInst[opcodeHi:opcodeLo];
	assign funct3 = exInst[funct3Hi:funct3Lo];
	assign altBit = exInst[altBitPos];

	// shared funct3 table of register and immediate ops
	function automatic aluOpT decodeAlu(input logic [2:0] f3, input logic alt,
			input logic isReg);
		case (f3)
			// sub exists only in register form
			f3Add: decodeAlu = (isReg && alt) ? aluSub : aluAdd;
			f3Sll: decodeAlu = aluSll;
			f3Slt: decodeAlu = aluSlt;
			f3Sltu: decodeAlu = aluSltu;
			f3Xor: decodeAlu = aluXor;
			f3Sr: decodeAlu = alt ? aluSra : aluSrl;
			f3Or: decodeAlu = aluOr;
			f3And: decodeAlu = aluAnd;
			default: decodeAlu = aluAdd;
		endcase
		// bit 30 on any other register op falls back to add
		if (isReg && alt && (f3 != f3Add) && (f3 != f3Sr))
			decodeAlu = aluAdd;
	endfunction

	always_comb begin
		// idle values, kept for empty and unknown slots
		aluSel = aluAdd;
		immSel = immR;
		aSel = 1'b0;
		bSel = 1'b0;
		brUn = 1'b0;
		pcSel = 1'b0;
		if (exValid) begin
			case (opcode)
				opReg: begin
					aluSel = decodeAlu(funct3, altBit, 1'b1);
				end
				opImm: begin
					aluSel = decodeAlu(funct3, altBit, 1'b0);
					// shifts carry a 5-bit shamt
					immSel = ((funct3 == f3Sll) || (funct3 == f3Sr)) ? immShift : immI;
					bSel = 1'b1;
				end
				opLoad: begin
					immSel = immI;
					bSel = 1'b1;
				end
				opStore: begin
					immSel = immS;
					bSel = 1'b1;
				end
				opBranch: begin
					// target is pc + offset
					immSel = immB;
					aSel = 1'b1;
					bSel = 1'b1;
					brUn = (funct3 == f3Bltu) || (funct3 == f3Bgeu);
					case (funct3)
						f3Beq: pcSel = brEq;
						f3Bne: pcSel = !brEq;
						f3Blt, f3Bltu: pcSel = brLt;
						f3Bge, f3Bgeu: pcSel = !brLt;
						// funct3 2 and 3 are not branches
						default: pcSel = 1'b0;
					endcase
				end
				opLui: begin
					aluSel = aluPassB;
					immSel = immU;
					bSel = 1'b1;
				end
				opAuipc: begin
					immSel = immU;
					aSel = 1'b1;
					bSel = 1'b1;
				end
				opJal: begin
					immSel = immJ;
					aSel = 1'b1;
					bSel = 1'b1;
					pcSel = 1'b1;
				end
				opJalr: begin
					// target is rs1 + imm
					immSel = immI;
					bSel = 1'b1;
					pcSel = 1'b1;
				end
				default: begin
					pcSel = 1'b0;
				end
			endcase
		end
	end

endmodule

// File: source/memoryControl.sv
`timescale 1ns/10ps
// ================================================
// memory stage decode: write enable and access size
// reads are implied by a load in the slot
// there is no separate read strobe
// store with funct3 above 2 writes a byte
// ================================================
module memoryControl (
	input  logic [rvIsaPkg::instWidth-1:0] memInst,
	input  logic                          memValid,
	output logic                          memWrite,
	output ctrlPkg::memWidthT             memWidth
);
	import rvIsaPkg::*;
	import ctrlPkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;

	assign opcode = memInst[opcodeHi:opcodeLo];
	assign funct3 = memInst[funct3Hi:funct3Lo];

	always_comb begin
		memWrite = 1'b0;
		memWidth = widthByte;
		if (memValid) begin
			case (opcode)
				opStore: begin
					memWrite = 1'b1;
					// no unsigned stores
					case (funct3)
						f3Half: memWidth = widthHalf;
						f3Word: memWidth = widthWord;
						default: memWidth = widthByte;
					endcase
				end
				opLoad: begin
					case (funct3)
						f3Half: memWidth = widthHalf;
						f3Word: memWidth = widthWord;
						f3ByteU: memWidth = widthByteU;
						f3HalfU: memWidth = widthHalfU;
						default: memWidth = widthByte;
					endcase
				end
				// everything else leaves memory alone
				default: memWrite = 1'b0;
			endcase
		end
	end

endmodule

// File: source/writebackControl.sv
`timescale 1ns/10ps
// ================================================
// writeback stage decode: register write enable
// and write data source
// stores, branches, empty and unknown slots
// never write the register file
// ================================================
module writebackControl (
	input  logic [rvIsaPkg::instWidth-1:0] wbInst,
	input  logic                          wbValid,
	output logic                          regWrite,
	output ctrlPkg::wbSelT                wbSel
);
	import rvIsaPkg::*;
	import ctrlPkg::*;

	logic [6:0] opcode;

	assign opcode = wbInst[opcodeHi:opcodeLo];

	always_comb begin
		regWrite = 1'b0;
		wbSel = wbMem;
		if (wbValid) begin
			case (opcode)
				opLoad: begin
					regWrite = 1'b1;
					wbSel = wbMem;
				end
				// link address
				opJal, opJalr: begin
					regWrite = 1'b1;
					wbSel = wbPc4;
				end
				opReg, opImm, opLui, opAuipc: begin
					regWrite = 1'b1;
					wbSel = wbAlu;
				end
				default: regWrite = 1'b0;
			endcase
		end
	end

endmodule

// File: source/controlPipeline.sv
`timescale 1ns/10ps
// ================================================
// RV32I control path, stage registers plus the
// execute, memory and writeback decoders
// EX controls 1 cycle after accept, MEM 2, WB 3
// stall holds all stages and ignores inst
// ================================================
module controlPipeline (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          stall,
	input  logic [rvIsaPkg::instWidth-1:0] inst,
	input  logic                          instValid,
	input  logic                          brEq,
	input  logic                          brLt,
	output ctrlPkg::aluOpT                aluSel,
	output ctrlPkg::immSelT               immSel,
	output logic                          aSel,
	output logic                          bSel,
	output logic                          brUn,
	output logic                          pcSel,
	output logic                          memWrite,
	output ctrlPkg::memWidthT             memWidth,
	output logic                          regWrite,
	output ctrlPkg::wbSelT                wbSel
);
	import rvIsaPkg::*;

	// per-stage instruction and valid flag
	logic [instWidth-1:0] exInst;
	logic [instWidth-1:0] memInst;
	logic [instWidth-1:0] wbInst;
	logic exValid;
	logic memValid;
	logic wbValid;

	instPipe u_instPipe (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.inst(inst),
		.instValid(instValid),
		.exInst(exInst),
		.exValid(exValid),
		.memInst(memInst),
		.memValid(memValid),
		.wbInst(wbInst),
		.wbValid(wbValid)
	);

	// each decoder sees only its own stage
	executeControl u_executeControl (
		.exInst(exInst),
		.exValid(exValid),
		.brEq(brEq),
		.brLt(brLt),
		.aluSel(aluSel),
		.immSel(immSel),
		.aSel(aSel),
		.bSel(bSel),
		.brUn(brUn),
		.pcSel(pcSel)
	);

	memoryControl u_memoryControl (
		.memInst(memInst),
		.memValid(memValid),
		.memWrite(memWrite),
		.memWidth(memWidth)
	);

	writebackControl u_writebackControl (
		.wbInst(wbInst),
		.wbValid(wbValid),
		.regWrite(regWrite),
		.wbSel(wbSel)
	);

endmodule

// File: tests/ctrlChecker.sv
`timescale 1ns/10ps
// ================================================
// checker for controlPipeline
// keeps its own EX/MEM/WB copy of accepted words
// and compares every output at the falling edge
// a stalled edge must leave all outputs except
// pcSel unchanged, pcSel follows brEq/brLt
// ================================================
module ctrlChecker (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           stall,
	input  logic [rvIsaPkg::instWidth-1:0] inst,
	input  logic                           instValid,
	input  logic                           brEq,
	input  logic                           brLt,
	input  logic [ctrlPkg::aluSelBits-1:0]   aluSel,
	input  logic [ctrlPkg::immSelBits-1:0]   immSel,
	input  logic                           aSel,
	input  logic                           bSel,
	input  logic                           brUn,
	input  logic                           pcSel,
	input  logic                           memWrite,
	input  logic [ctrlPkg::memWidthBits-1:0] memWidth,
	input  logic                           regWrite,
	input  logic [ctrlPkg::wbSelBits-1:0]    wbSel,
	input  logic                           finishRun,
	output logic                           reportDone,
	output int                             errorCount
);
	import rvIsaPkg::*;
	import ctrlPkg::*;

	// model stage contents
	logic [instWidth-1:0] exWord;
	logic [instWidth-1:0] memWord;
	logic [instWidth-1:0] wbWord;
	logic exFull;
	logic memFull;
	logic wbFull;
	// what the last rising edge did
	logic stalledEdge;
	logic resetEdge;
	logic [16:0] prevOutputs;
	int checks [6];
	int errors [6];

	function automatic string testLabel(input int t);
		case (t)
			0: return "reset";
			1: return "execute decode";
			2: return "branch resolution";
			3: return "memory and writeback decode";
			4: return "stall hold";
			default: return "idle and unknown slots";
		endcase
	endfunction

	function automatic logic knownOp(input logic [6:0] op);
		case (op)
			opReg, opImm, opLoad, opStore, opBranch, opLui, opAuipc, opJal, opJalr:
				return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// funct3 table of register and immediate forms
	function automatic logic [3:0] aluFromTable(input logic [2:0] f3, input logic alt,
			input logic isReg);
		logic [3:0] op;
		case (f3)
			3'd0: op = aluAdd;
			3'd1: op = aluSll;
			3'd2: op = aluSlt;
			3'd3: op = aluSltu;
			3'd4: op = aluXor;
			3'd5: op = aluSrl;
			3'd6: op = aluOr;
			default: op = aluAnd;
		endcase
		// bit 30 gives sra, sub only in register form, other pairs add
		if (alt && f3 == 3'd5)
			op = aluSra;
		else if (alt && isReg)
			op = (f3 == 3'd0) ? aluSub : aluAdd;
		return op;
	endfunction

	function automatic logic branchTaken(input logic [2:0] f3, input logic eq, input logic lt);
		case (f3)
			3'd0: return eq;
			3'd1: return !eq;
			3'd4, 3'd6: return lt;
			3'd5, 3'd7: return !lt;
			default: return 1'b0;
		endcase
	endfunction

	task automatic expectExecute(input logic [instWidth-1:0] word, input logic valid,
			input logic eq, input logic lt, output logic [3:0] alu, output logic [2:0] imm,
			output logic a, output logic b, output logic un, output logic pc);
		logic [2:0] f3;
		logic [6:0] op;
		f3 = word[funct3Hi:funct3Lo];
		op = word[opcodeHi:opcodeLo];
		alu = aluAdd;
		imm = immR;
		a = 1'b0;
		b = 1'b0;
		un = 1'b0;
		pc = 1'b0;
		if (valid) begin
			// immediate on operand b for all but register ops
			b = knownOp(op) && (op != opReg);
			case (op)
				opReg: alu = aluFromTable(f3, word[altBitPos], 1'b1);
				opImm: begin
					alu = aluFromTable(f3, word[altBitPos], 1'b0);
					imm = (f3 == 3'd1 || f3 == 3'd5) ? immShift : immI;
				end
				opLoad: imm = immI;
				opStore: imm = immS;
				opBranch: begin
					imm = immB;
					a = 1'b1;
					un = f3[2] && f3[1];
					pc = branchTaken(f3, eq, lt);
				end
				opLui: begin
					alu = aluPassB;
					imm = immU;
				end
				opAuipc: begin
					imm = immU;
					a = 1'b1;
				end
				opJal: begin
					imm = immJ;
					a = 1'b1;
					pc = 1'b1;
				end
				opJalr: begin
					imm = immI;
					pc = 1'b1;
				end
				default: b = 1'b0;
			endcase
		end
	endtask

	task automatic expectMemory(input logic [instWidth-1:0] word, input logic valid,
			output logic wr, output logic [2:0] width);
		logic [2:0] f3;
		f3 = word[funct3Hi:funct3Lo];
		wr = valid && (word[opcodeHi:opcodeLo] == opStore);
		width = widthByte;
		// stores have no unsigned sizes
		if (wr || (valid && word[opcodeHi:opcodeLo] == opLoad)) begin
			case (f3)
				3'd1: width = widthHalf;
				3'd2: width = widthWord;
				3'd4: width = wr ? widthByte : widthByteU;
				3'd5: width = wr ? widthByte : widthHalfU;
				default: width = widthByte;
			endcase
		end
	endtask

	task automatic expectWriteback(input logic [instWidth-1:0] word, input logic valid,
			output logic rw, output logic [1:0] sel);
		rw = 1'b0;
		sel = wbMem;
		if (valid) begin
			case (word[opcodeHi:opcodeLo])
				opLoad: rw = 1'b1;
				opJal, opJalr: begin
					rw = 1'b1;
					sel = wbPc4;
				end
				opReg, opImm, opLui, opAuipc: begin
					rw = 1'b1;
					sel = wbAlu;
				end
				default: rw = 1'b0;
			endcase
		end
	endtask

	// reset slot, decoded slot or idle slot
	function automatic int slotTest(input logic valid, input logic [instWidth-1:0] word,
			input int decodeTest);
		if (reset || resetEdge)
			return 0;
		if (valid && knownOp(word[opcodeHi:opcodeLo]))
			return decodeTest;
		return 5;
	endfunction

	task automatic compare(input int test, input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks[test] = checks[test] + 1;
		if (actual !== expected) begin
			errors[test] = errors[test] + 1;
			$display("** Error at %0t ns: %s expected %0h, got %0h", $time, name,
				expected, actual);
		end
	endtask

	// model of the stage registers
	always @(posedge clk) begin
		if (reset) begin
			exFull <= 1'b0;
			memFull <= 1'b0;
			wbFull <= 1'b0;
		end else if (!stall) begin
			exFull <= instValid;
			memFull <= exFull;
			wbFull <= memFull;
		end
		if (!stall) begin
			exWord <= inst;
			memWord <= exWord;
			wbWord <= memWord;
		end
		stalledEdge <= stall && !reset;
		resetEdge <= reset;
	end

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		logic [3:0] expAlu;
		logic [2:0] expImm;
		logic expA;
		logic expB;
		logic expUn;
		logic expPc;
		logic expWr;
		logic [2:0] expWidth;
		logic expRw;
		logic [1:0] expWb;
		logic [16:0] nowOutputs;
		int exTest;
		int memTest;
		int wbTest;
		expectExecute(exWord, exFull, brEq, brLt, expAlu, expImm, expA, expB, expUn, expPc);
		expectMemory(memWord, memFull, expWr, expWidth);
		expectWriteback(wbWord, wbFull, expRw, expWb);
		exTest = slotTest(exFull, exWord, 1);
		memTest = slotTest(memFull, memWord, 3);
		wbTest = slotTest(wbFull, wbWord, 3);
		compare(exTest, "aluSel", 32'(expAlu), 32'(aluSel));
		compare(exTest, "immSel", 32'(expImm), 32'(immSel));
		compare(exTest, "aSel", 32'(expA), 32'(aSel));
		compare(exTest, "bSel", 32'(expB), 32'(bSel));
		compare(exTest, "brUn", 32'(expUn), 32'(brUn));
		compare((reset || resetEdge) ? 0 : 2, "pcSel", 32'(expPc), 32'(pcSel));
		compare(memTest, "memWrite", 32'(expWr), 32'(memWrite));
		compare(memTest, "memWidth", 32'(expWidth), 32'(memWidth));
		compare(wbTest, "regWrite", 32'(expRw), 32'(regWrite));
		compare(wbTest, "wbSel", 32'(expWb), 32'(wbSel));
		// everything but pcSel, which follows the live flags
		nowOutputs = {aluSel, immSel, aSel, bSel, brUn, memWrite, memWidth, regWrite, wbSel};
		if (stalledEdge)
			compare(4, "outputs held by stall", 32'(prevOutputs), 32'(nowOutputs));
		prevOutputs = nowOutputs;
		// first cycle out of reset closes the reset test
		if (resetEdge && !reset)
			$display("test 1 %s: %0d checks, %0d errors", testLabel(0), checks[0], errors[0]);
	end

	always @(posedge clk) begin
		int total;
		int failed;
		if (reset) begin
			reportDone <= 1'b0;
			errorCount <= 0;
		end else if (finishRun && !reportDone) begin
			total = 0;
			failed = 0;
			for (int t = 0; t < 6; t++) begin
				if (t > 0)
					$display("test %0d %s: %0d checks, %0d errors", t + 1, testLabel(t),
						checks[t], errors[t]);
				if (checks[t] == 0) begin
					$display("test %0d %s never ran a single check", t + 1, testLabel(t));
					failed = failed + 1;
				end
				total = total + checks[t];
				failed = failed + errors[t];
			end
			$display("counts: %0d checks, %0d errors", total, failed);
			errorCount <= failed;
			reportDone <= 1'b1;
		end
	end

endmodule

// File: tests/tbControlPipeline.sv
`timescale 1ns/10ps
// ================================================
// testbench for controlPipeline
// random RV32I words, about 1 in 4 with an unknown
// opcode, stall about 20% of cycles
// inst and instValid are held while stall is high
// fixed seed
// ctrlChecker does all the comparing
// ================================================
module tbControlPipeline;
	import rvIsaPkg::*;
	import ctrlPkg::*;

	localparam int randomCycles = 3000;
	localparam int drainCycles = 8;
	localparam int reportTimeout = 20;

	// DUT inputs
	logic clk;
	logic reset;
	logic stall;
	logic [instWidth-1:0] inst;
	logic instValid;
	logic brEq;
	logic brLt;

	// DUT outputs
	aluOpT aluSel;
	immSelT immSel;
	logic aSel;
	logic bSel;
	logic brUn;
	logic pcSel;
	logic memWrite;
	memWidthT memWidth;
	logic regWrite;
	wbSelT wbSel;

	// end of run handshake with the checker
	logic finishRun;
	logic reportDone;
	int errorCount;

	controlPipeline u_controlPipeline (.*);

	ctrlChecker u_ctrlChecker (.*);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// random word with the opcode mostly from the nine known classes
	function automatic logic [instWidth-1:0] randomInst();
		logic [instWidth-1:0] word;
		int pick;
		word = $urandom;
		pick = $urandom % 12;
		case (pick)
			0: word[opcodeHi:opcodeLo] = opReg;
			1: word[opcodeHi:opcodeLo] = opImm;
			2: word[opcodeHi:opcodeLo] = opLoad;
			3: word[opcodeHi:opcodeLo] = opStore;
			4: word[opcodeHi:opcodeLo] = opBranch;
			5: word[opcodeHi:opcodeLo] = opLui;
			6: word[opcodeHi:opcodeLo] = opAuipc;
			7: word[opcodeHi:opcodeLo] = opJal;
			8: word[opcodeHi:opcodeLo] = opJalr;
			// a random 7-bit pattern is nearly always unknown
			default: word[opcodeHi:opcodeLo] = 7'($urandom);
		endcase
		return word;
	endfunction

	// next inputs just after each rising edge
	task automatic driveRandom();
		// a new word only once the current one was taken
		if (!stall) begin
			inst <= randomInst();
			instValid <= ($urandom % 4) != 0;
		end
		stall <= ($urandom % 5) == 0;
		brEq <= 1'($urandom);
		brLt <= 1'($urandom);
	endtask

	// empty slots to flush the pipe
	task automatic driveIdle();
		if (!stall)
			instValid <= 1'b0;
		stall <= 1'b0;
		brEq <= 1'($urandom);
		brLt <= 1'($urandom);
	endtask

	initial begin
		int cycle;
		int waitCount;
		void'($urandom(32'hf496));
		reset = 1'b1;
		stall = 1'b0;
		inst = '0;
		instValid = 1'b0;
		brEq = 1'b0;
		brLt = 1'b0;
		finishRun = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		for (cycle = 0; cycle < randomCycles; cycle++) begin
			@(posedge clk);
			driveRandom();
		end
		for (cycle = 0; cycle < drainCycles; cycle++) begin
			@(posedge clk);
			driveIdle();
		end
		// ask the checker for its report
		finishRun <= 1'b1;
		waitCount = 0;
		while (!reportDone && waitCount < reportTimeout) begin
			@(posedge clk);
			waitCount++;
		end
		if (!reportDone) begin
			$display("checker report did not arrive within %0d cycles", reportTimeout);
			$display("*** FAILED ***");
		end else if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: project.f
source/rvIsaPkg.sv
source/ctrlPkg.sv
source/instPipe.sv
source/executeControl.sv
source/memoryControl.sv
source/writebackControl.sv
source/controlPipeline.sv
tests/ctrlChecker.sv
tests/tbControlPipeline.sv

// File: run.sh
#!/bin/bash
# builds the control pipeline testbench with Verilator and runs it
# the run fails when the log holds the fail message

rm -rf obj_dir
verilator --binary --timing --assert --top-module tbControlPipeline -f project.f \
	-o simControlPipeline > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

# a crashed simulation counts as a failure
./obj_dir/simControlPipeline > sim.log 2>&1 \
	|| echo "*** FAILED ***" >> sim.log
cat sim.log

grep -q '\*\*\* FAILED \*\*\*' sim.log \
	&& { echo "simulation failed"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
